// ==== src/soc_bus_pkg.sv ====
package soc_bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [8:0]  ram_index_t;
    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] half_t;
    typedef logic [2:0]  prio_t;

    // stores only use the first four codes
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    typedef enum logic [2:0] {
        T_RAM,
        T_SDRAM,
        T_PLIC,
        T_MTIMECMP,
        T_MTIME,
        T_NONE
    } target_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DECODE,
        S_WAIT,
        S_DONE
    } ctrl_state_e;

    // access as latched by the controller
    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        ls_type_e ls_type;
        logic     write;
    } bus_req_t;

    typedef struct packed {
        sdram_addr_t addr;
        half_t       wrdata;
        logic [1:0]  byte_en;
        logic        write_en;
        logic        read_en;
    } sdram_cmd_t;

    localparam addr_t RAM_BASE  = 64'h0;
    localparam addr_t RAM_BYTES = 64'd2048;
    localparam int    RAM_WORDS = 512;

    localparam addr_t SDRAM_BASE  = 64'h8000_0000;
    localparam addr_t SDRAM_BYTES = 64'h0080_0000;

    localparam addr_t MTIME_ADDR    = 64'h0200_BFF8;
    localparam addr_t MTIMECMP_ADDR = 64'h0200_4000;

    localparam addr_t PLIC_BASE          = 64'h0C00_0000;
    localparam addr_t PLIC_BYTES         = 64'h0040_0000;
    localparam addr_t PLIC_PENDING       = PLIC_BASE + 64'h1000;
    localparam addr_t PLIC_ENABLE        = PLIC_BASE + 64'h2000;
    localparam addr_t PLIC_THRESHOLD     = PLIC_BASE + 64'h20_0000;
    localparam addr_t PLIC_CLAIM         = PLIC_BASE + 64'h20_0004;
    localparam addr_t PLIC_ENABLE_STRIDE = 64'h80;
    localparam addr_t PLIC_CTX_STRIDE    = 64'h1000;
    localparam int    PLIC_SOURCES       = 6;
    localparam int    UART_SOURCE_ID     = 1;

    localparam data_t MTIMECMP_RESET = 64'h8000_0000;

    // low bits of raw hold the loaded value
    function automatic data_t extend_load(data_t raw, ls_type_e kind);
        case (kind)
            LS_B:    return {{56{raw[7]}}, raw[7:0]};
            LS_H:    return {{48{raw[15]}}, raw[15:0]};
            LS_W:    return {{32{raw[31]}}, raw[31:0]};
            LS_BU:   return {56'b0, raw[7:0]};
            LS_HU:   return {48'b0, raw[15:0]};
            LS_WU:   return {32'b0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

endpackage

// ==== src/plic_regs.sv ====
`timescale 1ns/1ps

module plic_regs import soc_bus_pkg::*; (
    input  logic     clock_slow,
    input  logic     KEY0,
    input  bus_req_t req,
    input  logic     start,
    output data_t    rdata,
    output logic     ack,
    input  logic     irq_source,
    output logic     meip,
    output logic     msip
);

    prio_t      prio [PLIC_SOURCES];
    word_t      pending;
    word_t      enable [2];
    prio_t      threshold [2];
    word_t      claim_id [2];
    logic       irq_prev;
    logic       prio_sel;
    logic [2:0] prio_id;
    logic [1:0] en_sel;
    logic [1:0] th_sel;
    logic [1:0] cl_sel;
    data_t      reg_val;

    assign prio_id  = req.addr[4:2];
    assign prio_sel = (req.addr < PLIC_PENDING) && (req.addr[11:2] < PLIC_SOURCES);

    // register decode and read mux per context
    always_comb begin
        reg_val = '0;
        if (prio_sel) begin
            reg_val = data_t'(prio[prio_id]);
        end else if (req.addr == PLIC_PENDING) begin
            reg_val = data_t'(pending);
        end
        for (int c = 0; c < 2; c++) begin
            // only the uart source is wired
            claim_id[c] = (pending[UART_SOURCE_ID] && enable[c][UART_SOURCE_ID])
                        ? word_t'(UART_SOURCE_ID) : '0;
            en_sel[c] = (req.addr == PLIC_ENABLE + PLIC_ENABLE_STRIDE * addr_t'(c));
            th_sel[c] = (req.addr == PLIC_THRESHOLD + PLIC_CTX_STRIDE * addr_t'(c));
            cl_sel[c] = (req.addr == PLIC_CLAIM + PLIC_CTX_STRIDE * addr_t'(c));
            if (en_sel[c]) reg_val = data_t'(enable[c]);
            if (th_sel[c]) reg_val = data_t'(threshold[c]);
            if (cl_sel[c]) reg_val = data_t'(claim_id[c]);
        end
    end

    assign meip = (claim_id[0] != '0);
    assign msip = (claim_id[1] != '0);

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < PLIC_SOURCES; i++) prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
            pending  <= '0;
            irq_prev <= 1'b0;
            rdata    <= '0;
            ack      <= 1'b0;
        end else begin
            ack      <= start;
            irq_prev <= irq_source;
            if (start && !req.write) begin
                rdata <= reg_val;
                // a claim read takes the source off the pending map
                for (int c = 0; c < 2; c++) begin
                    if (cl_sel[c] && claim_id[c] != '0) pending[claim_id[c][4:0]] <= 1'b0;
                end
            end
            if (start && req.write) begin
                if (prio_sel) prio[prio_id] <= req.wdata[2:0];
                for (int c = 0; c < 2; c++) begin
                    if (en_sel[c]) enable[c] <= req.wdata[31:0];
                    if (th_sel[c]) threshold[c] <= req.wdata[2:0];
                end
            end
            // a new edge wins over a claim in the same cycle
            if (irq_source && !irq_prev) pending[UART_SOURCE_ID] <= 1'b1;
        end
    end

endmodule

// ==== src/ram_lanes.sv ====
`timescale 1ns/1ps

module ram_lanes import soc_bus_pkg::*; (
    input  logic     clock_slow,
    input  logic     KEY0,
    input  bus_req_t req,
    input  logic     start,
    output data_t    rdata,
    output logic     ack
);

    word_t      mem [RAM_WORDS];
    ram_index_t idx;
    ram_index_t idx_next;
    logic [1:0] off;
    logic       is_double;
    logic       second;
    word_t      lo_word;
    word_t      hi_word;
    word_t      shifted;

    assign idx       = req.addr[10:2];
    assign idx_next  = idx + 9'd1;
    assign off       = req.addr[1:0];
    assign is_double = (req.ls_type == LS_D);

    // doubleword takes a second cycle for the upper word
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            second <= 1'b0;
            ack    <= 1'b0;
        end else begin
            second <= start && is_double;
            ack    <= (start && !is_double) || second;
        end
    end

    always_ff @(posedge clock_slow) begin
        if (start) begin
            lo_word <= mem[idx];
            if (req.write) begin
                case (req.ls_type)
                    LS_B:    mem[idx][8*off +: 8] <= req.wdata[7:0];
                    LS_H:    mem[idx][16*off[1] +: 16] <= req.wdata[15:0];
                    default: mem[idx] <= req.wdata[31:0];
                endcase
            end
        end
        if (second) begin
            hi_word <= mem[idx_next];
            if (req.write) begin
                mem[idx_next] <= req.wdata[63:32];
            end
        end
    end

    // narrow loads come from the addressed lane
    assign shifted = lo_word >> {off, 3'b000};
    assign rdata   = is_double ? {hi_word, lo_word}
                               : extend_load({32'b0, shifted}, req.ls_type);

endmodule

// ==== src/sdram_bridge.sv ====
`timescale 1ns/1ps

module sdram_bridge import soc_bus_pkg::*; (
    input  logic       clock_slow,
    input  logic       KEY0,
    input  bus_req_t   req,
    input  logic       start,
    output data_t      rdata,
    output logic       ack,
    output sdram_cmd_t cmd,
    input  half_t      sdram_rddata,
    input  logic       sdram_ready,
    input  logic       sdram_req_wait
);

    logic       busy;
    logic       beat;
    logic [1:0] step;
    logic [1:0] last_step;
    logic       is_byte;
    logic       beat_done;
    data_t      raw;
    data_t      aligned;

    assign is_byte   = (req.ls_type == LS_B) || (req.ls_type == LS_BU);
    assign beat_done = beat && !sdram_req_wait;

    // one beat per halfword
    always_comb begin
        case (req.ls_type)
            LS_W, LS_WU: last_step = 2'd1;
            LS_D:        last_step = 2'd3;
            default:     last_step = 2'd0;
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            busy <= 1'b0;
            beat <= 1'b0;
            step <= '0;
            ack  <= 1'b0;
            cmd  <= '0;
        end else begin
            ack <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy && !beat && sdram_ready) begin
                cmd.addr <= req.addr[22:1] + sdram_addr_t'(step);
                if (is_byte) begin
                    // same byte on both halves and byte_en picks the lane
                    cmd.wrdata  <= {2{req.wdata[7:0]}};
                    cmd.byte_en <= req.addr[0] ? 2'b10 : 2'b01;
                end else begin
                    cmd.wrdata  <= req.wdata[16*step +: 16];
                    cmd.byte_en <= 2'b11;
                end
                cmd.write_en <= req.write;
                cmd.read_en  <= !req.write;
                beat         <= 1'b1;
            end else if (beat_done) begin
                cmd.write_en <= 1'b0;
                cmd.read_en  <= 1'b0;
                beat         <= 1'b0;
                if (step == last_step) begin
                    busy <= 1'b0;
                    ack  <= 1'b1;
                end else begin
                    step <= step + 2'd1;
                end
            end
        end
    end

    // little-endian assembly with the lowest half first
    always_ff @(posedge clock_slow) begin
        if (beat_done && !req.write) begin
            raw[16*step +: 16] <= sdram_rddata;
        end
    end

    assign aligned = (is_byte && req.addr[0]) ? {8'b0, raw[63:8]} : raw;
    assign rdata   = extend_load(aligned, req.ls_type);

endmodule

// ==== src/bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller import soc_bus_pkg::*; (
    input  logic     clock_slow,
    input  logic     KEY0,
    input  logic     read_enable,
    input  logic     write_enable,
    input  addr_t    address,
    input  ls_type_e ls_type,
    input  data_t    write_data,
    input  data_t    mtime,
    output data_t    read_data,
    output logic     read_done,
    output logic     write_done,
    output bus_req_t req,
    output logic     ram_start,
    output logic     sdram_start,
    output logic     plic_start,
    input  logic     ram_ack,
    input  logic     sdram_ack,
    input  logic     plic_ack,
    input  data_t    ram_rdata,
    input  data_t    sdram_rdata,
    input  data_t    plic_rdata
);

    ctrl_state_e state;
    target_e     target;
    data_t       mtimecmp;
    logic        ack_sel;
    data_t       rdata_sel;
    logic        accept;

    assign accept = (state == S_IDLE) && (read_enable || write_enable);

    // offsets wrap below the base, so one unsigned compare covers a range
    always_comb begin
        if ((req.addr - RAM_BASE) < RAM_BYTES) begin
            target = T_RAM;
        end else if ((req.addr - SDRAM_BASE) < SDRAM_BYTES) begin
            target = T_SDRAM;
        end else if (req.addr == MTIME_ADDR) begin
            target = T_MTIME;
        end else if (req.addr == MTIMECMP_ADDR) begin
            target = T_MTIMECMP;
        end else if ((req.addr - PLIC_BASE) < PLIC_BYTES) begin
            target = T_PLIC;
        end else begin
            target = T_NONE;
        end
    end

    assign ram_start   = (state == S_DECODE) && (target == T_RAM);
    assign sdram_start = (state == S_DECODE) && (target == T_SDRAM);
    assign plic_start  = (state == S_DECODE) && (target == T_PLIC);

    always_comb begin
        case (target)
            T_RAM: begin
                ack_sel   = ram_ack;
                rdata_sel = ram_rdata;
            end
            T_SDRAM: begin
                ack_sel   = sdram_ack;
                rdata_sel = sdram_rdata;
            end
            T_PLIC: begin
                ack_sel   = plic_ack;
                rdata_sel = plic_rdata;
            end
            default: begin
                ack_sel   = 1'b0;
                rdata_sel = '0;
            end
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            state      <= S_IDLE;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            mtimecmp   <= MTIMECMP_RESET;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        read_done  <= !read_enable;
                        write_done <= !write_enable;
                        state      <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    // timer registers and holes finish here
                    if (target inside {T_MTIME, T_MTIMECMP, T_NONE}) begin
                        state <= S_DONE;
                    end else begin
                        state <= S_WAIT;
                    end
                    if (target == T_MTIMECMP && req.write) begin
                        mtimecmp <= req.wdata;
                    end
                end
                S_WAIT: begin
                    if (ack_sel) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    read_done  <= 1'b1;
                    write_done <= 1'b1;
                    state      <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock_slow) begin
        if (accept) begin
            req.addr    <= address;
            req.wdata   <= write_data;
            req.ls_type <= ls_type;
            req.write   <= write_enable;
        end
        if (!req.write) begin
            if (state == S_DECODE) begin
                case (target)
                    T_MTIME:    read_data <= mtime;
                    T_MTIMECMP: read_data <= mtimecmp;
                    T_NONE:     read_data <= '0;
                    default:    ;
                endcase
            end else if (state == S_WAIT && ack_sel) begin
                read_data <= rdata_sel;
            end
        end
    end

endmodule

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; (
    input  logic       clock_slow,
    input  logic       KEY0,
    // processor side
    input  logic       read_enable,
    input  logic       write_enable,
    input  addr_t      address,
    input  ls_type_e   ls_type,
    input  data_t      write_data,
    output data_t      read_data,
    output logic       read_done,
    output logic       write_done,
    input  data_t      mtime,
    // interrupts
    input  logic       irq_source,
    output logic       meip,
    output logic       msip,
    // external SDRAM controller
    output sdram_cmd_t sdram_cmd,
    input  half_t      sdram_rddata,
    input  logic       sdram_ready,
    input  logic       sdram_req_wait
);

    bus_req_t req;
    logic     ram_start, sdram_start, plic_start;
    logic     ram_ack, sdram_ack, plic_ack;
    data_t    ram_rdata, sdram_rdata, plic_rdata;

    bus_controller u_ctrl (
        .clock_slow   (clock_slow),
        .KEY0         (KEY0),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .address      (address),
        .ls_type      (ls_type),
        .write_data   (write_data),
        .mtime        (mtime),
        .read_data    (read_data),
        .read_done    (read_done),
        .write_done   (write_done),
        .req          (req),
        .ram_start    (ram_start),
        .sdram_start  (sdram_start),
        .plic_start   (plic_start),
        .ram_ack      (ram_ack),
        .sdram_ack    (sdram_ack),
        .plic_ack     (plic_ack),
        .ram_rdata    (ram_rdata),
        .sdram_rdata  (sdram_rdata),
        .plic_rdata   (plic_rdata)
    );

    ram_lanes u_ram (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .req        (req),
        .start      (ram_start),
        .rdata      (ram_rdata),
        .ack        (ram_ack)
    );

    sdram_bridge u_sdram (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .req            (req),
        .start          (sdram_start),
        .rdata          (sdram_rdata),
        .ack            (sdram_ack),
        .cmd            (sdram_cmd),
        .sdram_rddata   (sdram_rddata),
        .sdram_ready    (sdram_ready),
        .sdram_req_wait (sdram_req_wait)
    );

    plic_regs u_plic (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .req        (req),
        .start      (plic_start),
        .rdata      (plic_rdata),
        .ack        (plic_ack),
        .irq_source (irq_source),
        .meip       (meip),
        .msip       (msip)
    );

endmodule

// ==== verif/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus import soc_bus_pkg::*; ();

    localparam int    RESET_CYCLES    = 8;
    localparam int    CYCLES_PER_STEP = 200;
    localparam data_t MTIME_VALUE     = 64'h0000_0042_1234_5678;
    localparam addr_t UNMAPPED_A      = 64'h1000_0000;
    localparam addr_t UNMAPPED_B      = 64'h0200_0000;
    // sdram window inside the part of the model that is kept
    localparam addr_t SD              = SDRAM_BASE + 64'h100;

    typedef enum logic [1:0] {
        K_WRITE,
        K_READ,
        K_PULSE,
        K_LINES
    } kind_e;

    typedef struct {
        string    name;
        kind_e    kind;
        addr_t    addr;
        ls_type_e ls;
        data_t    data;
        data_t    expected;
    } step_t;

    logic       clock_slow;
    logic       KEY0;
    logic       read_enable;
    logic       write_enable;
    addr_t      address;
    ls_type_e   ls_type;
    data_t      write_data;
    data_t      read_data;
    logic       read_done;
    logic       write_done;
    data_t      mtime;
    logic       irq_source;
    logic       meip;
    logic       msip;
    sdram_cmd_t sdram_cmd;
    half_t      sdram_rddata;
    logic       sdram_ready;
    logic       sdram_req_wait;

    step_t       steps[$];
    logic        table_built;
    logic [31:0] rng_state;
    // low 1K halfwords only, higher addresses alias
    half_t       sdram_mem [1024];
    logic        beat_seen;
    int          wait_left;
    int          ready_gap;

    soc_bus_top u_dut (
        .clock_slow     (clock_slow),
        .KEY0           (KEY0),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .address        (address),
        .ls_type        (ls_type),
        .write_data     (write_data),
        .read_data      (read_data),
        .read_done      (read_done),
        .write_done     (write_done),
        .mtime          (mtime),
        .irq_source     (irq_source),
        .meip           (meip),
        .msip           (msip),
        .sdram_cmd      (sdram_cmd),
        .sdram_rddata   (sdram_rddata),
        .sdram_ready    (sdram_ready),
        .sdram_req_wait (sdram_req_wait)
    );

    initial clock_slow = 1'b0;
    always #4 clock_slow = ~clock_slow;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // one halfword beat where byte_en picks the lanes for stores
    task automatic serve_beat();
        if (sdram_cmd.write_en) begin
            if (sdram_cmd.byte_en[0]) begin
                sdram_mem[sdram_cmd.addr[9:0]][7:0] = sdram_cmd.wrdata[7:0];
            end
            if (sdram_cmd.byte_en[1]) begin
                sdram_mem[sdram_cmd.addr[9:0]][15:8] = sdram_cmd.wrdata[15:8];
            end
        end else begin
            sdram_rddata = sdram_mem[sdram_cmd.addr[9:0]];
        end
    endtask

    // sdram controller model with random ready gaps and wait states
    always begin
        @(posedge clock_slow);
        #1;
        if (sdram_cmd.read_en === 1'b1 || sdram_cmd.write_en === 1'b1) begin
            if (!beat_seen) begin
                beat_seen = 1'b1;
                wait_left = int'((next_random() >> 16) & 32'd3);
            end
            if (wait_left != 0) begin
                sdram_req_wait = 1'b1;
                wait_left--;
            end else begin
                sdram_req_wait = 1'b0;
                serve_beat();
            end
        end else begin
            if (beat_seen) begin
                beat_seen = 1'b0;
                ready_gap = int'((next_random() >> 16) & 32'd3);
            end
            sdram_req_wait = 1'b0;
            sdram_ready    = (ready_gap == 0);
            if (ready_gap != 0) begin
                ready_gap--;
            end
        end
    end

    function automatic void add_step(input string name, input kind_e kind, input addr_t addr,
                                     input ls_type_e ls, input data_t data,
                                     input data_t expected);
        step_t s;
        s.name     = name;
        s.kind     = kind;
        s.addr     = addr;
        s.ls       = ls;
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endfunction

    task automatic build_table();
        // timer registers with holes in the map read in between
        add_step("mtimecmp reset", K_READ, MTIMECMP_ADDR, LS_D, '0, 64'h8000_0000);
        add_step("unmapped read a", K_READ, UNMAPPED_A, LS_D, '0, 64'h0);
        add_step("mtimecmp write", K_WRITE, MTIMECMP_ADDR, LS_D, 64'h0123_4567_89AB_CDEF, '0);
        add_step("mtimecmp back", K_READ, MTIMECMP_ADDR, LS_D, '0, 64'h0123_4567_89AB_CDEF);
        add_step("unmapped write", K_WRITE, UNMAPPED_A, LS_D, 64'hDEAD_BEEF, '0);
        add_step("unmapped read b", K_READ, UNMAPPED_B, LS_W, '0, 64'h0);
        add_step("mtime read", K_READ, MTIME_ADDR, LS_D, '0, MTIME_VALUE);
        // ram stores into words 4 and 5 then 8 and 9
        add_step("ram sd", K_WRITE, 64'h10, LS_D, 64'hFEDC_BA98_7654_3210, '0);
        add_step("ram sw", K_WRITE, 64'h20, LS_W, 64'h1111_1111_8081_8283, '0);
        add_step("ram sb 21", K_WRITE, 64'h21, LS_B, 64'hA5, '0);
        add_step("ram sh 22", K_WRITE, 64'h22, LS_H, 64'h7E01, '0);
        add_step("ram sw 24", K_WRITE, 64'h24, LS_W, '0, '0);
        add_step("ram sb 24", K_WRITE, 64'h24, LS_B, 64'h5A, '0);
        add_step("ram sb 27", K_WRITE, 64'h27, LS_B, 64'hC3, '0);
        // ram loads
        add_step("ram ld 10", K_READ, 64'h10, LS_D, '0, 64'hFEDC_BA98_7654_3210);
        add_step("ram lw 14", K_READ, 64'h14, LS_W, '0, 64'hFFFF_FFFF_FEDC_BA98);
        add_step("ram lwu 14", K_READ, 64'h14, LS_WU, '0, 64'h0000_0000_FEDC_BA98);
        add_step("ram lw 10", K_READ, 64'h10, LS_W, '0, 64'h0000_0000_7654_3210);
        add_step("ram lb 20", K_READ, 64'h20, LS_B, '0, 64'hFFFF_FFFF_FFFF_FF83);
        add_step("ram lbu 20", K_READ, 64'h20, LS_BU, '0, 64'h83);
        add_step("ram lb 21", K_READ, 64'h21, LS_B, '0, 64'hFFFF_FFFF_FFFF_FFA5);
        add_step("ram lbu 23", K_READ, 64'h23, LS_BU, '0, 64'h7E);
        add_step("ram lh 20", K_READ, 64'h20, LS_H, '0, 64'hFFFF_FFFF_FFFF_A583);
        add_step("ram lhu 20", K_READ, 64'h20, LS_HU, '0, 64'hA583);
        add_step("ram lh 22", K_READ, 64'h22, LS_H, '0, 64'h7E01);
        add_step("ram lw 20", K_READ, 64'h20, LS_W, '0, 64'h7E01_A583);
        add_step("ram lw 24", K_READ, 64'h24, LS_W, '0, 64'hFFFF_FFFF_C300_005A);
        add_step("ram lwu 24", K_READ, 64'h24, LS_WU, '0, 64'hC300_005A);
        add_step("ram ld 20", K_READ, 64'h20, LS_D, '0, 64'hC300_005A_7E01_A583);
        add_step("ram lb 27", K_READ, 64'h27, LS_B, '0, 64'hFFFF_FFFF_FFFF_FFC3);
        add_step("ram lhu 26", K_READ, 64'h26, LS_HU, '0, 64'hC300);
        // sdram stores into halfwords 0x80 to 0x87
        add_step("sdram sd", K_WRITE, SD, LS_D, 64'h0102_0304_0506_0708, '0);
        add_step("sdram sw", K_WRITE, SD + 64'h8, LS_W, 64'h89AB_CDEF, '0);
        add_step("sdram sh", K_WRITE, SD + 64'hC, LS_H, 64'hF00D, '0);
        add_step("sdram sb e", K_WRITE, SD + 64'hE, LS_B, 64'h11, '0);
        add_step("sdram sb f", K_WRITE, SD + 64'hF, LS_B, 64'h92, '0);
        // sdram loads
        add_step("sdram ld 0", K_READ, SD, LS_D, '0, 64'h0102_0304_0506_0708);
        add_step("sdram lw 0", K_READ, SD, LS_W, '0, 64'h0506_0708);
        add_step("sdram lwu 4", K_READ, SD + 64'h4, LS_WU, '0, 64'h0102_0304);
        add_step("sdram lw 8", K_READ, SD + 64'h8, LS_W, '0, 64'hFFFF_FFFF_89AB_CDEF);
        add_step("sdram lwu 8", K_READ, SD + 64'h8, LS_WU, '0, 64'h89AB_CDEF);
        add_step("sdram lh c", K_READ, SD + 64'hC, LS_H, '0, 64'hFFFF_FFFF_FFFF_F00D);
        add_step("sdram lhu c", K_READ, SD + 64'hC, LS_HU, '0, 64'hF00D);
        add_step("sdram lb e", K_READ, SD + 64'hE, LS_B, '0, 64'h11);
        add_step("sdram lb f", K_READ, SD + 64'hF, LS_B, '0, 64'hFFFF_FFFF_FFFF_FF92);
        add_step("sdram lbu f", K_READ, SD + 64'hF, LS_BU, '0, 64'h92);
        add_step("sdram ld 8", K_READ, SD + 64'h8, LS_D, '0, 64'h9211_F00D_89AB_CDEF);
        // interrupt controller
        // line checks expect meip in bit 0 and msip in bit 1
        add_step("plic prio1 w", K_WRITE, PLIC_BASE + 64'h4, LS_W, 64'h5, '0);
        add_step("plic prio2 w", K_WRITE, PLIC_BASE + 64'h8, LS_W, 64'h3, '0);
        add_step("plic prio3 w", K_WRITE, PLIC_BASE + 64'hC, LS_W, 64'hF, '0);
        add_step("plic prio1 r", K_READ, PLIC_BASE + 64'h4, LS_WU, '0, 64'h5);
        add_step("plic prio2 r", K_READ, PLIC_BASE + 64'h8, LS_WU, '0, 64'h3);
        add_step("plic prio3 r", K_READ, PLIC_BASE + 64'hC, LS_WU, '0, 64'h7);
        add_step("plic thresh w", K_WRITE, PLIC_THRESHOLD, LS_W, 64'h2, '0);
        add_step("plic thresh r", K_READ, PLIC_THRESHOLD, LS_WU, '0, 64'h2);
        add_step("irq idle", K_LINES, '0, LS_W, '0, 64'h0);
        add_step("plic enable w", K_WRITE, PLIC_ENABLE, LS_W, 64'h2, '0);
        add_step("plic enable r", K_READ, PLIC_ENABLE, LS_WU, '0, 64'h2);
        add_step("uart pulse", K_PULSE, '0, LS_W, '0, '0);
        add_step("irq raised", K_LINES, '0, LS_W, '0, 64'h1);
        add_step("plic pending", K_READ, PLIC_PENDING, LS_WU, '0, 64'h2);
        add_step("plic claim ctx1", K_READ, PLIC_CLAIM + PLIC_CTX_STRIDE, LS_WU, '0, 64'h0);
        add_step("plic claim ctx0", K_READ, PLIC_CLAIM, LS_WU, '0, 64'h1);
        add_step("irq claimed", K_LINES, '0, LS_W, '0, 64'h0);
        add_step("plic pending clr", K_READ, PLIC_PENDING, LS_WU, '0, 64'h0);
    endtask

    // one processor access that returns with done high again
    task automatic run_access(input step_t s, output data_t rdata);
        address    = s.addr;
        ls_type    = s.ls;
        write_data = s.data;
        if (s.kind == K_WRITE) begin
            write_enable = 1'b1;
        end else begin
            read_enable = 1'b1;
        end
        @(posedge clock_slow);
        #1;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        check_bit({s.name, " done low"}, 1'b0, (s.kind == K_WRITE) ? write_done : read_done);
        while (!((s.kind == K_WRITE) ? write_done : read_done)) begin
            @(posedge clock_slow);
            #1;
        end
        rdata = read_data;
    endtask

    task automatic pulse_irq();
        irq_source = 1'b1;
        @(posedge clock_slow);
        #1;
        irq_source = 1'b0;
        @(posedge clock_slow);
        #1;
    endtask

    initial begin
        data_t got;
        table_built    = 1'b0;
        KEY0           = 1'b0;
        read_enable    = 1'b0;
        write_enable   = 1'b0;
        address        = '0;
        ls_type        = LS_D;
        write_data     = '0;
        mtime          = MTIME_VALUE;
        irq_source     = 1'b0;
        sdram_rddata   = '0;
        sdram_ready    = 1'b1;
        sdram_req_wait = 1'b0;
        rng_state      = 32'h4166;
        beat_seen      = 1'b0;
        wait_left      = 0;
        ready_gap      = 0;
        for (int i = 0; i < 1024; i++) begin
            sdram_mem[i] = '0;
        end
        build_table();
        table_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock_slow);
        #1;
        KEY0 = 1'b1;

        check_bit("read_done after reset", 1'b1, read_done);
        check_bit("write_done after reset", 1'b1, write_done);
        check_bit("meip after reset", 1'b0, meip);
        check_bit("msip after reset", 1'b0, msip);
        check_bit("sdram read_en after reset", 1'b0, sdram_cmd.read_en);
        check_bit("sdram write_en after reset", 1'b0, sdram_cmd.write_en);

        foreach (steps[i]) begin
            case (steps[i].kind)
                K_PULSE: begin
                    pulse_irq();
                end
                K_LINES: begin
                    check_bit({steps[i].name, " meip"}, steps[i].expected[0], meip);
                    check_bit({steps[i].name, " msip"}, steps[i].expected[1], msip);
                end
                default: begin
                    run_access(steps[i], got);
                    if (steps[i].kind == K_READ) begin
                        check_data(steps[i].name, steps[i].expected, got);
                    end
                end
            endcase
        end

        $display("Test OK");
        $finish;
    end

    // budget grows with the table
    initial begin
        wait (table_built === 1'b1);
        repeat (RESET_CYCLES + steps.size() * CYCLES_PER_STEP) @(posedge clock_slow);
        abort_run("watchdog timeout: an access never completed");
    end

endmodule

// ==== flist.f ====
src/soc_bus_pkg.sv
src/plic_regs.sv
src/ram_lanes.sv
src/sdram_bridge.sv
src/bus_controller.sv
src/soc_bus_top.sv
verif/tb_soc_bus.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the bus fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_bus -f flist.f -o sim_tb_soc_bus
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_tb_soc_bus
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
